/* Makefile */
SIM := obj_dir/VneoCore_tb
SRCS := compile.f $(wildcard include/*.svh logic/*.sv bench/*.sv)

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --assert --top-module neoCore_tb -f compile.f -o VneoCore_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '^NO ERRORS$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* bench/neoCore_assert.sv */
`default_nettype none

module neoCore_assert
	import neoBusPkg::*, neoVideoPkg::*;
(
	input logic        clk24M,
	input logic        reset,
	input cpuBus       bus,
	input logic        dtack,
	input pixelRequest pixelIn,
	input rgbPixel     rgbOut
);

	// DTACK only answers a strobe seen on the clock before
	dtackNeedsStrobe: assert property (@(posedge clk24M) disable iff (reset)
		dtack |-> $past(bus.addrStrobe))
		else $error("dtack high without a preceding address strobe");

	dtackDrops: assert property (@(posedge clk24M) disable iff (reset)
		!bus.addrStrobe |=> !dtack)                     // Released one clock after AS
		else $error("dtack still high after the address strobe dropped");

	// Lookup plus DAC register
	pixelLatency: assert property (@(posedge clk24M) disable iff (reset)
		rgbOut.valid == $past(pixelIn.valid, 2))
		else $error("rgb valid does not follow pixel valid by two clocks");

endmodule

bind neoCore neoCore_assert timingChecks (
	.clk24M  (clk24M),
	.reset   (reset),
	.bus     (bus),
	.dtack   (dtack),
	.pixelIn (pixelIn),
	.rgbOut  (rgbOut)
);

`default_nettype wire

/* bench/neoCore_tb.sv */
`default_nettype none

`include "neo_macros.svh"

module neoCore_tb
	import neoBusPkg::*, neoVideoPkg::*;
();

	logic clk24M;
	logic reset;
	cpuBus bus;
	logic [`NEO_DATA_W-1:0] extData;
	logic romWait;
	pixelRequest pixelIn;
	logic dtack;
	logic [`NEO_DATA_W-1:0] readData;
	zoneSelect zones;
	sysFlags flags;
	rgbPixel rgbOut;

	sysFlags expFlags;          // Latch model
	logic [15:0] bank0 [16];
	logic [15:0] bank1 [16];
	logic [11:0] idx [16];      // Palette indices under test
	int errors;
	int checks;
	int testErrors;

	// Region bases in zoneSelect field order, writes where the strobe is a WE
	localparam logic [23:0] zoneBase [12] = '{`NEO_ROM_BASE, `NEO_PORT_BASE, `NEO_WRAM_BASE,
		`NEO_WRAM_BASE, `NEO_CTRL1_BASE, `NEO_CTRL2_BASE, `NEO_STATB_BASE, `NEO_LSPC_BASE,
		`NEO_LSPC_BASE, `NEO_CARD_BASE, `NEO_CARD_BASE, `NEO_BIOS_BASE};
	localparam logic [11:0] zoneWrites = 12'b0010_0000_1010;

	neoCore dut (.*);

	always #5 clk24M = ~clk24M;

	task automatic compareWord(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compareZones(input string name, input zoneSelect got, input zoneSelect exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compareFlags(input string name, input sysFlags got, input sysFlags exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compareRgb(input string name, input rgbPixel got, input rgbPixel exp);
		checks++;
		if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin   // Idle only checks valid
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// Weighted sum of the resistor ladder, dark pulls the two bottom bits
	function automatic logic [6:0] componentLevel(input logic [3:0] high, input logic low,
			input logic dark, input logic shade);
		int v;
		v = high * 8 + low * 4 + (dark ? 0 : 3);
		if (shade)
			v = v / 2;
		return 7'(v);
	endfunction

	function automatic rgbPixel expectRgb(input paletteWord w, input logic shade);
		rgbPixel p;
		p.valid = 1'b1;
		p.red = componentLevel(w.rHigh, w.r0, w.dark, shade);
		p.green = componentLevel(w.gHigh, w.g0, w.dark, shade);
		p.blue = componentLevel(w.bHigh, w.b0, w.dark, shade);
		return p;
	endfunction

	function automatic logic [23:0] palAddr(input logic [11:0] index);
		return `NEO_PAL_BASE | {11'h0, index, 1'b0};
	endfunction

	// One 68K cycle, held until dtack, called 1 unit after a rising edge
	task automatic runCycle(input logic [23:0] addr, input logic write, input logic [15:0] data,
			input logic lowerOnly, output logic [15:0] rdata, output zoneSelect seen,
			output int latency);
		int cycles;
		cycles = 0;
		bus = '{addr: addr[23:1], dataOut: data, rw: ~write, addrStrobe: 1'b1,
			lowerStrobe: 1'b1, upperStrobe: ~lowerOnly};
		do begin
			@(posedge clk24M);
			#1;
			cycles++;
		end while (!dtack && cycles < 20);
		if (!dtack) begin
			errors++;
			$display("Timeout waiting for dtack at address %h", addr);
		end
		rdata = readData;
		seen = zones;
		latency = cycles - 1;       // First edge is the cycle start
		bus = '0;
		@(posedge clk24M);          // dtack drops here
		#1;
	endtask

	task automatic busWrite(input logic [23:0] addr, input logic [15:0] data);
		logic [15:0] rdata;
		zoneSelect seen;
		int lat;
		runCycle(addr, 1'b1, data, 1'b0, rdata, seen, lat);
	endtask

	task automatic busRead(input logic [23:0] addr, output logic [15:0] rdata);
		zoneSelect seen;
		int lat;
		runCycle(addr, 1'b0, 16'h0, 1'b0, rdata, seen, lat);
	endtask

	// Odd byte write into the latch, A4 is the value
	task automatic setFlag(input int sel, input logic value);
		logic [15:0] rdata;
		zoneSelect seen;
		int lat;
		logic [7:0] model;
		runCycle(`NEO_SLATCH_BASE | {19'h0, value, 3'(sel), 1'b1}, 1'b1, 16'h0, 1'b1,
			rdata, seen, lat);
		model = expFlags;
		model[7 - sel] = value;     // Field 0 is the MSB
		expFlags = model;
		compareFlags("flags", flags, expFlags);
	endtask

	task automatic reportTest(input string name);
		$display("%s: %0d errors", name, errors - testErrors);
		testErrors = errors;
	endtask

	task automatic checkReset();
		expFlags = '0;
		expFlags.systemRom = 1'b1;  // BIOS at boot
		compareWord("dtack", 16'(dtack), 16'h0);
		compareZones("zones", zones, '0);
		compareRgb("rgbOut", rgbOut, '0);
		compareFlags("flags", flags, expFlags);
	endtask

	task automatic decodeZones();
		logic [15:0] rdata;
		zoneSelect seen;
		int lat;
		for (int i = 0; i < 12; i++) begin
			extData = 16'($urandom);
			runCycle(zoneBase[i], zoneWrites[11 - i], 16'h0, 1'b0, rdata, seen, lat);
			compareZones("zones", seen, zoneSelect'(12'h800 >> i));
			if (!zoneWrites[11 - i])
				compareWord("readData", rdata, extData);
		end
	endtask

	task automatic exerciseLatch();
		for (int sel = 0; sel < 8; sel++) begin
			setFlag(sel, 1'b1);
			setFlag(sel, 1'b0);
		end
		setFlag(5, 1'b1);           // Back to BIOS
	endtask

	task automatic bankPalette();
		logic [15:0] rdata;
		for (int i = 0; i < 16; i++) begin
			idx[i] = (12'($urandom) & 12'hFF0) | 12'(i);    // Unique low nibble
			bank0[i] = 16'($urandom);
			bank1[i] = bank0[i] ^ (16'($urandom) | 16'h1);  // Never equal
			busWrite(palAddr(idx[i]), bank0[i]);
		end
		setFlag(7, 1'b1);
		for (int i = 0; i < 16; i++)
			busWrite(palAddr(idx[i]), bank1[i]);
		for (int i = 0; i < 16; i++) begin
			busRead(palAddr(idx[i]), rdata);
			compareWord("readData", rdata, bank1[i]);
		end
		setFlag(7, 1'b0);
		for (int i = 0; i < 16; i++) begin
			busRead(palAddr(idx[i]), rdata);
			compareWord("readData", rdata, bank0[i]);
			busRead(24'h5FE000 | {11'h0, idx[i], 1'b0}, rdata);   // 8 KB mirror
			compareWord("readData", rdata, bank0[i]);
		end
	endtask

	// Back to back lookups, result expected two edges after each request
	task automatic streamPixels(input logic shade);
		for (int s = 0; s <= 16; s++) begin
			pixelIn = '{valid: s < 16, index: idx[s % 16]};
			@(posedge clk24M);
			#1;
			if (s == 0)
				compareRgb("rgbOut", rgbOut, '0);
			else
				compareRgb("rgbOut", rgbOut, expectRgb(bank0[s - 1], shade));
		end
		pixelIn = '0;
		@(posedge clk24M);
		#1;
		compareRgb("rgbOut", rgbOut, '0);
	endtask

	task automatic playVideo();
		bank0[0] = bank0[0] | 16'h8000;     // Dark set
		bank0[1] = bank0[1] & 16'h7FFF;
		busWrite(palAddr(idx[0]), bank0[0]);
		busWrite(palAddr(idx[1]), bank0[1]);
		streamPixels(1'b0);
		setFlag(0, 1'b1);                   // Shadow on
		streamPixels(1'b1);
		setFlag(0, 1'b0);
	endtask

	task automatic measureRomWait();
		logic [15:0] rdata;
		zoneSelect seen;
		int fastLat;
		int slowLat;
		int palLat;
		romWait = 1'b0;
		runCycle(`NEO_ROM_BASE, 1'b0, 16'h0, 1'b0, rdata, seen, fastLat);
		romWait = 1'b1;
		runCycle(`NEO_ROM_BASE, 1'b0, 16'h0, 1'b0, rdata, seen, slowLat);
		runCycle(palAddr(idx[0]), 1'b0, 16'h0, 1'b0, rdata, seen, palLat);
		romWait = 1'b0;
		compareWord("dtack delay", 16'(fastLat), 16'(`NEO_DTACK_DELAY));
		compareWord("dtack extra wait", 16'(slowLat - fastLat), 16'(`NEO_ROM_WAIT));
		compareWord("dtack palette delay", 16'(palLat), 16'(`NEO_DTACK_DELAY));
	endtask

	initial begin
		void'($urandom(32'heccd_0a00));
		clk24M = 1'b0;
		reset = 1'b1;
		bus = '0;
		extData = '0;
		romWait = 1'b0;
		pixelIn = '0;
		errors = 0;
		checks = 0;
		testErrors = 0;
		repeat (10) @(posedge clk24M);
		#1;
		reset = 1'b0;
		checkReset();
		reportTest("reset state");
		decodeZones();
		reportTest("zone decode");
		exerciseLatch();
		reportTest("system latch");
		bankPalette();
		reportTest("palette banking");
		playVideo();
		reportTest("video path");
		measureRomWait();
		reportTest("rom wait");
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
logic/neoBusPkg.sv
logic/neoVideoPkg.sv
logic/busDecoder.sv
logic/systemLatch.sv
logic/paletteRam.sv
logic/videoOut.sv
logic/neoCore.sv
bench/neoCore_assert.sv
bench/neoCore_tb.sv

/* include/neo_macros.svh */
`ifndef NEO_MACROS_SVH
`define NEO_MACROS_SVH

// Bus widths
`define NEO_ADDR_W        23        // Word address, byte bits 23..1
`define NEO_DATA_W        16
`define NEO_PAL_INDEX_W   12        // Entries per palette bank
`define NEO_RGB_W         7         // DAC resolution per component

// DTACK timing in clocks
`define NEO_DTACK_DELAY   2         // Internal zones
`define NEO_ROM_WAIT      2         // Added on ROM and port when the cart asks

// Memory map, byte addresses
`define NEO_ROM_BASE      24'h000000
`define NEO_WRAM_BASE     24'h100000
`define NEO_PORT_BASE     24'h200000
`define NEO_CTRL1_BASE    24'h300000
`define NEO_CTRL2_BASE    24'h340000
`define NEO_STATB_BASE    24'h380000
`define NEO_SLATCH_BASE   24'h3A0000
`define NEO_LSPC_BASE     24'h3C0000
`define NEO_PAL_BASE      24'h400000
`define NEO_CARD_BASE     24'h800000
`define NEO_BIOS_BASE     24'hC00000

// Region size masks
`define NEO_MASK_4M       24'hC00000
`define NEO_MASK_1M       24'hF00000
`define NEO_MASK_128K     24'hFE0000

`endif

/* logic/busDecoder.sv */
`default_nettype none

`include "neo_macros.svh"

module busDecoder
	import neoBusPkg::*, neoVideoPkg::*;
(
	input  logic                        clk24M,
	input  logic                        reset,
	input  cpuBus                       bus,
	input  logic                        romWait,
	input  logic [`NEO_DATA_W-1:0]      extData,
	input  paletteWord                  paletteReadCpu,
	output logic                        dtack,
	output logic [`NEO_DATA_W-1:0]      readData,
	output zoneSelect                   zones,
	output busZone                      zone,
	output logic                        paletteWrite,
	output logic [`NEO_PAL_INDEX_W-1:0] paletteAddrCpu,
	output logic                        latchWrite,
	output logic [3:0]                  latchAddr
);

	typedef enum logic [1:0] {stIdle, stBusy, stAck} busState;

	localparam int waitW = $clog2(`NEO_DTACK_DELAY + `NEO_ROM_WAIT + 1);
	localparam logic [waitW-1:0] fastWait = waitW'(`NEO_DTACK_DELAY - 1);
	localparam logic [waitW-1:0] slowWait = waitW'(`NEO_DTACK_DELAY + `NEO_ROM_WAIT - 1);

	busState state;
	logic [waitW-1:0] waitCount;    // Clocks left before DTACK
	logic [23:0] byteAddr;
	logic startCycle;
	logic isWrite;
	busZone hitZone;
	zoneSelect hitSelect;

	// Address window test against a base and a size mask
	function automatic logic inRegion(input logic [23:0] a, input logic [23:0] base,
			input logic [23:0] mask);
		return ((a ^ base) & mask) == 24'h0;
	endfunction

	assign byteAddr = {bus.addr, 1'b0};
	assign isWrite = ~bus.rw;
	assign startCycle = (state == stIdle) & bus.addrStrobe;

	always_comb begin
		hitZone = zoneNone;
		if (inRegion(byteAddr, `NEO_BIOS_BASE, `NEO_MASK_4M))
			hitZone = zoneBios;
		else if (inRegion(byteAddr, `NEO_CARD_BASE, `NEO_MASK_4M))
			hitZone = zoneCard;
		else if (inRegion(byteAddr, `NEO_PAL_BASE, `NEO_MASK_4M))
			hitZone = zonePalette;      // 8 KB mirrors over 4 MB
		else if (inRegion(byteAddr, `NEO_ROM_BASE, `NEO_MASK_1M))
			hitZone = zoneRom;
		else if (inRegion(byteAddr, `NEO_WRAM_BASE, `NEO_MASK_1M))
			hitZone = zoneWorkRam;
		else if (inRegion(byteAddr, `NEO_PORT_BASE, `NEO_MASK_1M))
			hitZone = zonePort;
		else if (inRegion(byteAddr, `NEO_CTRL1_BASE, `NEO_MASK_128K))
			hitZone = zoneCtrl1;
		else if (inRegion(byteAddr, `NEO_CTRL2_BASE, `NEO_MASK_128K))
			hitZone = zoneCtrl2;
		else if (inRegion(byteAddr, `NEO_STATB_BASE, `NEO_MASK_128K))
			hitZone = zoneStatusB;
		else if (inRegion(byteAddr, `NEO_SLATCH_BASE, `NEO_MASK_128K) && isWrite && bus.lowerStrobe)
			hitZone = zoneSysLatch;     // Odd byte writes only
		else if (inRegion(byteAddr, `NEO_LSPC_BASE, `NEO_MASK_128K))
			hitZone = zoneLspc;
	end

	// One strobe per region, direction picks OE or WE
	always_comb begin
		hitSelect = '0;
		case (hitZone)
			zoneRom:     hitSelect.romOe = bus.rw;
			zonePort:    hitSelect.portOe = bus.rw;
			zoneWorkRam: begin
				hitSelect.workRamOe = bus.rw;
				hitSelect.workRamWe = isWrite;
			end
			zoneCtrl1:   hitSelect.ctrl1 = 1'b1;
			zoneCtrl2:   hitSelect.ctrl2 = 1'b1;
			zoneStatusB: hitSelect.statusB = 1'b1;
			zoneLspc: begin
				hitSelect.lspcOe = bus.rw;
				hitSelect.lspcWe = isWrite;
			end
			zoneCard: begin
				hitSelect.cardOe = bus.rw;
				hitSelect.cardWe = isWrite;
			end
			zoneBios:    hitSelect.biosOe = bus.rw;
			default:     hitSelect = '0;
		endcase
	end

	always_ff @(posedge clk24M) begin
		if (reset) begin
			state <= stIdle;
			waitCount <= '0;
			zone <= zoneNone;
			zones <= '0;
			dtack <= 1'b0;
		end else begin
			case (state)
				stIdle: if (bus.addrStrobe) begin
					state <= stBusy;
					zone <= hitZone;
					zones <= hitSelect;
					// Cart may stretch ROM and port accesses
					if (romWait && (hitZone == zoneRom || hitZone == zonePort))
						waitCount <= slowWait;
					else
						waitCount <= fastWait;
				end
				stBusy: if (!bus.addrStrobe) begin
					state <= stIdle;        // Aborted cycle
					zone <= zoneNone;
					zones <= '0;
				end else if (waitCount == '0) begin
					state <= stAck;
					dtack <= 1'b1;
				end else begin
					waitCount <= waitCount - 1'b1;
				end
				stAck: if (!bus.addrStrobe) begin
					state <= stIdle;
					dtack <= 1'b0;
					zone <= zoneNone;
					zones <= '0;
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Side effects fire on the first clock only
	assign paletteWrite = startCycle & isWrite & (hitZone == zonePalette)
		& (bus.upperStrobe | bus.lowerStrobe);
	assign latchWrite = startCycle & (hitZone == zoneSysLatch);
	assign paletteAddrCpu = bus.addr[`NEO_PAL_INDEX_W-1:0];  // Mirror drops upper bits
	assign latchAddr = bus.addr[3:0];                       // Byte bits 4..1

	always_comb begin
		case (zone)
			zonePalette:  readData = paletteReadCpu;
			zoneSysLatch: readData = '1;
			zoneNone:     readData = '1;    // Open bus
			default:      readData = extData;
		endcase
	end

endmodule

`default_nettype wire

/* logic/neoBusPkg.sv */
`default_nettype none

`include "neo_macros.svh"

package neoBusPkg;

	// 68K bus as seen from the board, strobes already active high
	typedef struct packed {
		logic [`NEO_ADDR_W-1:0] addr;     // A23..A1
		logic [`NEO_DATA_W-1:0] dataOut;  // CPU write data
		logic                   rw;       // High on read
		logic                   addrStrobe;
		logic                   lowerStrobe; // Odd byte, D7..D0
		logic                   upperStrobe; // Even byte, D15..D8
	} cpuBus;

	// Decoded regions of the system map
	typedef enum logic [3:0] {
		zoneRom,
		zoneWorkRam,
		zonePort,
		zoneCtrl1,
		zoneCtrl2,
		zoneStatusB,
		zoneSysLatch,
		zoneLspc,
		zonePalette,
		zoneCard,
		zoneBios,
		zoneNone
	} busZone;

	// Chip selects toward the external regions
	typedef struct packed {
		logic romOe;
		logic portOe;
		logic workRamWe;
		logic workRamOe;
		logic ctrl1;
		logic ctrl2;
		logic statusB;
		logic lspcOe;
		logic lspcWe;
		logic cardOe;
		logic cardWe;
		logic biosOe;
	} zoneSelect;

	// System latch outputs, order matches latch address bits 3..1
	typedef struct packed {
		logic shadow;
		logic vecBios;
		logic cardWriteEn;
		logic cardWriteEnB;
		logic regEnable;
		logic systemRom;     // BIOS side selected
		logic sramUnlock;
		logic palBank;
	} sysFlags;

endpackage

`default_nettype wire

/* logic/neoCore.sv */
`default_nettype none

`include "neo_macros.svh"

module neoCore
	import neoBusPkg::*, neoVideoPkg::*;
(
	input  logic                   clk24M,
	input  logic                   reset,
	input  cpuBus                  bus,
	input  logic [`NEO_DATA_W-1:0] extData,     // Shared read data of external regions
	input  logic                   romWait,
	input  pixelRequest            pixelIn,
	output logic                   dtack,
	output logic [`NEO_DATA_W-1:0] readData,
	output zoneSelect              zones,
	output sysFlags                flags,
	output rgbPixel                rgbOut
);

	logic paletteWrite;
	logic [`NEO_PAL_INDEX_W-1:0] paletteAddrCpu;
	logic latchWrite;
	logic [3:0] latchAddr;
	paletteWord paletteReadCpu;
	paletteWord lookupWord;
	logic lookupValid;

	busDecoder decoder (
		.clk24M         (clk24M),
		.reset          (reset),
		.bus            (bus),
		.romWait        (romWait),
		.extData        (extData),
		.paletteReadCpu (paletteReadCpu),
		.dtack          (dtack),
		.readData       (readData),
		.zones          (zones),
		.zone           (),               // Enum kept for trace only
		.paletteWrite   (paletteWrite),
		.paletteAddrCpu (paletteAddrCpu),
		.latchWrite     (latchWrite),
		.latchAddr      (latchAddr)
	);

	systemLatch sysLatch (
		.clk24M     (clk24M),
		.reset      (reset),
		.latchWrite (latchWrite),
		.latchAddr  (latchAddr),
		.flags      (flags)
	);

	// CPU data goes straight into the palette word
	paletteRam palRam (
		.clk24M         (clk24M),
		.reset          (reset),
		.paletteWrite   (paletteWrite),
		.paletteAddrCpu (paletteAddrCpu),
		.writeData      (paletteWord'(bus.dataOut)),
		.palBank        (flags.palBank),
		.paletteReadCpu (paletteReadCpu),
		.pixelIn        (pixelIn),
		.lookupWord     (lookupWord),
		.lookupValid    (lookupValid)
	);

	videoOut vidOut (
		.clk24M      (clk24M),
		.reset       (reset),
		.lookupWord  (lookupWord),
		.lookupValid (lookupValid),
		.shadow      (flags.shadow),
		.rgbOut      (rgbOut)
	);

endmodule

`default_nettype wire

/* logic/neoVideoPkg.sv */
`default_nettype none

`include "neo_macros.svh"

package neoVideoPkg;

	// Palette RAM word as stored by the 68K
	typedef struct packed {
		logic       dark;    // Common dimming bit
		logic       r0;      // LSBs of each component
		logic       g0;
		logic       b0;
		logic [3:0] rHigh;
		logic [3:0] gHigh;
		logic [3:0] bHigh;
	} paletteWord;

	// Pixel side lookup into the current bank
	typedef struct packed {
		logic                        valid;
		logic [`NEO_PAL_INDEX_W-1:0] index;
	} pixelRequest;

	// Parallel RGB toward the DACs
	typedef struct packed {
		logic                  valid;
		logic [`NEO_RGB_W-1:0] red;
		logic [`NEO_RGB_W-1:0] green;
		logic [`NEO_RGB_W-1:0] blue;
	} rgbPixel;

endpackage

`default_nettype wire

/* logic/paletteRam.sv */
`default_nettype none

`include "neo_macros.svh"

module paletteRam
	import neoVideoPkg::*;
(
	input  logic                        clk24M,
	input  logic                        reset,
	input  logic                        paletteWrite,
	input  logic [`NEO_PAL_INDEX_W-1:0] paletteAddrCpu,
	input  paletteWord                  writeData,
	input  logic                        palBank,
	output paletteWord                  paletteReadCpu,
	input  pixelRequest                 pixelIn,
	output paletteWord                  lookupWord,
	output logic                        lookupValid
);

	localparam int palDepth = 2 ** (`NEO_PAL_INDEX_W + 1);   // Two banks

	paletteWord palMem [palDepth];
	logic [`NEO_PAL_INDEX_W:0] cpuAddr;
	logic [`NEO_PAL_INDEX_W:0] pixelAddr;

	// Bank bit on top of the index for both ports
	assign cpuAddr = {palBank, paletteAddrCpu};
	assign pixelAddr = {palBank, pixelIn.index};

	always_ff @(posedge clk24M) begin
		if (paletteWrite)
			palMem[cpuAddr] <= writeData;
	end

	// Async read feeds the decoder's data mux
	assign paletteReadCpu = palMem[cpuAddr];

	always_ff @(posedge clk24M) begin
		if (pixelIn.valid)
			lookupWord <= palMem[pixelAddr];
	end

	always_ff @(posedge clk24M) begin
		if (reset)
			lookupValid <= 1'b0;
		else
			lookupValid <= pixelIn.valid;
	end

endmodule

`default_nettype wire

/* logic/systemLatch.sv */
`default_nettype none

module systemLatch
	import neoBusPkg::*;
(
	input  logic       clk24M,
	input  logic       reset,
	input  logic       latchWrite,
	input  logic [3:0] latchAddr,
	output sysFlags    flags
);

	logic [2:0] flagSel;
	logic flagValue;

	assign flagSel = latchAddr[2:0];     // A3..A1
	assign flagValue = latchAddr[3];     // A4 carries the data

	// Addressable latch with one flag per write
	always_ff @(posedge clk24M) begin
		if (reset) begin
			flags <= '0;
			flags.systemRom <= 1'b1;         // Boot from BIOS
		end else if (latchWrite) begin
			case (flagSel)
				3'd0: flags.shadow <= flagValue;
				3'd1: flags.vecBios <= flagValue;       // Vector table source
				3'd2: flags.cardWriteEn <= flagValue;
				3'd3: flags.cardWriteEnB <= flagValue;
				3'd4: flags.regEnable <= flagValue;     // Card register space
				3'd5: flags.systemRom <= flagValue;
				3'd6: flags.sramUnlock <= flagValue;
				3'd7: flags.palBank <= flagValue;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/videoOut.sv */
`default_nettype none

`include "neo_macros.svh"

module videoOut
	import neoVideoPkg::*;
(
	input  logic       clk24M,
	input  logic       reset,
	input  paletteWord lookupWord,
	input  logic       lookupValid,
	input  logic       shadow,
	output rgbPixel    rgbOut
);

	logic [`NEO_RGB_W-1:0] redQ;
	logic [`NEO_RGB_W-1:0] greenQ;
	logic [`NEO_RGB_W-1:0] blueQ;
	logic validQ;

	// Nibble, LSB, then inverted dark twice for the bottom resistors
	function automatic logic [`NEO_RGB_W-1:0] expand(input logic [3:0] high, input logic low,
			input logic dark, input logic shade);
		logic [`NEO_RGB_W-1:0] level;
		level = {high, low, ~dark, ~dark};
		return shade ? (level >> 1) : level;   // Shadow halves intensity
	endfunction

	always_ff @(posedge clk24M) begin
		if (lookupValid) begin
			redQ <= expand(lookupWord.rHigh, lookupWord.r0, lookupWord.dark, shadow);
			greenQ <= expand(lookupWord.gHigh, lookupWord.g0, lookupWord.dark, shadow);
			blueQ <= expand(lookupWord.bHigh, lookupWord.b0, lookupWord.dark, shadow);
		end
	end

	always_ff @(posedge clk24M) begin
		if (reset)
			validQ <= 1'b0;
		else
			validQ <= lookupValid;
	end

	assign rgbOut = '{valid: validQ, red: redQ, green: greenQ, blue: blueQ};

endmodule

`default_nettype wire
